// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int NUM_REGS = 32;

	typedef logic [31:0] word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} op_e;

	// Function field under SPECIAL, inst[5:0]
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26
	} funct_e;

	typedef enum logic [2:0] {
		ALU_NOP = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_OR  = 3'd4,
		ALU_XOR = 3'd5,
		ALU_LUI = 3'd6
	} alu_op_e;

	typedef enum logic [1:0] {
		DBG_PC   = 2'd0,
		DBG_INST = 2'd1,
		DBG_REG  = 2'd2
	} dbg_src_e;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} wb_t;

	typedef struct packed {
		alu_op_e   alu_op;
		word_t     opnd_a;
		word_t     opnd_b;
		logic      wreg;
		reg_addr_t wd;
	} dec_t;

	typedef struct packed {
		dbg_src_e  src;
		reg_addr_t reg_addr;
	} dbg_sel_t;

endpackage

`default_nettype wire

// File: hw/if_id.sv
`timescale 1ns/1ns
`default_nettype none

module if_id #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  wire                 clk,
	input  wire                 arst_n_i,
	input  wire                 inst_valid_i,
	input  wire cpu_pkg::word_t inst_i,
	output cpu_pkg::word_t      pc_o,
	output cpu_pkg::word_t      id_inst_o
);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o      <= RESET_PC;
			id_inst_o <= '0;
		end else begin
			if (inst_valid_i) begin
				pc_o      <= pc_o + 32'd4;
				id_inst_o <= inst_i;
			end else begin
				// Bubble, all-zero word decodes as a no-op
				id_inst_o <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/id.sv
`timescale 1ns/1ns
`default_nettype none

module id (
	input  wire cpu_pkg::word_t id_inst_i,
	input  wire cpu_pkg::word_t rdata1_i,
	input  wire cpu_pkg::word_t rdata2_i,
	output cpu_pkg::reg_addr_t  raddr1_o,
	output cpu_pkg::reg_addr_t  raddr2_o,
	input  wire cpu_pkg::wb_t   ex_fwd_i,
	input  wire cpu_pkg::wb_t   wb_i,
	output cpu_pkg::dec_t       dec_o
);

	cpu_pkg::op_e       op;
	cpu_pkg::funct_e    funct;
	cpu_pkg::reg_addr_t rs;
	cpu_pkg::reg_addr_t rt;
	cpu_pkg::reg_addr_t rd;
	logic [15:0]        imm;
	cpu_pkg::word_t     rs_val;
	cpu_pkg::word_t     rt_val;

	// Youngest result wins, r0 never forwarded
	function automatic cpu_pkg::word_t fwd_sel(
		input cpu_pkg::reg_addr_t addr,
		input cpu_pkg::word_t     rf_data,
		input cpu_pkg::wb_t       ex_w,
		input cpu_pkg::wb_t       wb_w
	);
		if (addr != '0 && ex_w.wreg && ex_w.wd == addr) begin
			return ex_w.wdata;
		end else if (addr != '0 && wb_w.wreg && wb_w.wd == addr) begin
			return wb_w.wdata;
		end
		return rf_data;
	endfunction

	assign op    = cpu_pkg::op_e'(id_inst_i[31:26]);
	assign funct = cpu_pkg::funct_e'(id_inst_i[5:0]);
	assign rs    = id_inst_i[25:21];
	assign rt    = id_inst_i[20:16];
	assign rd    = id_inst_i[15:11];
	assign imm   = id_inst_i[15:0];

	assign raddr1_o = rs;
	assign raddr2_o = rt;

	assign rs_val = fwd_sel(rs, rdata1_i, ex_fwd_i, wb_i);
	assign rt_val = fwd_sel(rt, rdata2_i, ex_fwd_i, wb_i);

	always_comb begin
		dec_o.alu_op = cpu_pkg::ALU_NOP;
		dec_o.opnd_a = rs_val;
		dec_o.opnd_b = {16'h0000, imm};
		dec_o.wreg   = 1'b1;
		dec_o.wd     = rt;
		case (op)
			cpu_pkg::OP_SPECIAL: begin
				dec_o.opnd_b = rt_val;
				dec_o.wd     = rd;
				case (funct)
					cpu_pkg::FN_ADDU: dec_o.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: dec_o.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  dec_o.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   dec_o.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR:  dec_o.alu_op = cpu_pkg::ALU_XOR;
					default:          dec_o.wreg   = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDIU: begin
				dec_o.alu_op = cpu_pkg::ALU_ADD;
				dec_o.opnd_b = {{16{imm[15]}}, imm};
			end
			cpu_pkg::OP_ANDI: dec_o.alu_op = cpu_pkg::ALU_AND;
			cpu_pkg::OP_ORI:  dec_o.alu_op = cpu_pkg::ALU_OR;
			cpu_pkg::OP_XORI: dec_o.alu_op = cpu_pkg::ALU_XOR;
			cpu_pkg::OP_LUI: begin
				dec_o.alu_op = cpu_pkg::ALU_LUI;
				dec_o.opnd_b = {imm, 16'h0000};
			end
			// Anything else is a no-op
			default: dec_o.wreg = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input  wire                     clk,
	input  wire                     arst_n_i,
	input  wire cpu_pkg::wb_t       wb_i,
	input  wire cpu_pkg::reg_addr_t raddr1_i,
	input  wire cpu_pkg::reg_addr_t raddr2_i,
	input  wire cpu_pkg::reg_addr_t dbg_addr_i,
	output cpu_pkg::word_t          rdata1_o,
	output cpu_pkg::word_t          rdata2_o,
	output cpu_pkg::word_t          dbg_data_o
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	// r0 is cleared at reset and never written, so it always reads zero
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_i.wreg && wb_i.wd != '0) begin
				regs[wb_i.wd] <= wb_i.wdata;
			end
		end
	end

	// No write bypass here, id forwards the WB value
	assign rdata1_o   = regs[raddr1_i];
	assign rdata2_o   = regs[raddr2_i];
	assign dbg_data_o = regs[dbg_addr_i];

endmodule

`default_nettype wire

// File: hw/ex.sv
`timescale 1ns/1ns
`default_nettype none

module ex (
	input  wire                clk,
	input  wire                arst_n_i,
	input  wire cpu_pkg::dec_t dec_i,
	output cpu_pkg::wb_t       ex_fwd_o,
	output cpu_pkg::wb_t       wb_o
);

	cpu_pkg::dec_t id_ex_q;

	// ID/EX register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_q <= '0;
		end else begin
			id_ex_q <= dec_i;
		end
	end

	// ALU
	always_comb begin
		ex_fwd_o.wreg = id_ex_q.wreg;
		ex_fwd_o.wd   = id_ex_q.wd;
		case (id_ex_q.alu_op)
			cpu_pkg::ALU_ADD: begin
				ex_fwd_o.wdata = id_ex_q.opnd_a + id_ex_q.opnd_b;
			end
			cpu_pkg::ALU_SUB: begin
				ex_fwd_o.wdata = id_ex_q.opnd_a - id_ex_q.opnd_b;
			end
			cpu_pkg::ALU_AND: begin
				ex_fwd_o.wdata = id_ex_q.opnd_a & id_ex_q.opnd_b;
			end
			cpu_pkg::ALU_OR: begin
				ex_fwd_o.wdata = id_ex_q.opnd_a | id_ex_q.opnd_b;
			end
			cpu_pkg::ALU_XOR: begin
				ex_fwd_o.wdata = id_ex_q.opnd_a ^ id_ex_q.opnd_b;
			end
			// Immediate already shifted up in decode
			cpu_pkg::ALU_LUI: begin
				ex_fwd_o.wdata = id_ex_q.opnd_b;
			end
			default: begin
				ex_fwd_o.wdata = '0;
			end
		endcase
	end

	// EX/WB register, also the regfile write port
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_o <= '0;
		end else begin
			wb_o <= ex_fwd_o;
		end
	end

endmodule

`default_nettype wire

// File: hw/openmips_lite.sv
`timescale 1ns/1ns
`default_nettype none

module openmips_lite #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  wire                   clk,
	input  wire                   arst_n_i,
	input  wire                   inst_valid_i,
	input  wire cpu_pkg::word_t   inst_i,
	input  wire cpu_pkg::dbg_sel_t dbg_sel_i,
	output cpu_pkg::word_t        data_o
);

	cpu_pkg::word_t     pc;
	cpu_pkg::word_t     id_inst;
	cpu_pkg::reg_addr_t raddr1;
	cpu_pkg::reg_addr_t raddr2;
	cpu_pkg::word_t     rdata1;
	cpu_pkg::word_t     rdata2;
	cpu_pkg::word_t     reg_dbg_data;
	cpu_pkg::dec_t      id_dec;
	cpu_pkg::wb_t       ex_fwd;
	cpu_pkg::wb_t       wb;

	// Debug view
	always_comb begin
		case (dbg_sel_i.src)
			cpu_pkg::DBG_PC:   data_o = pc;
			cpu_pkg::DBG_INST: data_o = id_inst;
			cpu_pkg::DBG_REG:  data_o = reg_dbg_data;
			default:           data_o = '0;
		endcase
	end

	if_id #(
		.RESET_PC(RESET_PC)
	) if_id0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.inst_valid_i(inst_valid_i),
		.inst_i      (inst_i),
		.pc_o        (pc),
		.id_inst_o   (id_inst)
	);

	id id0 (
		.id_inst_i(id_inst),
		.rdata1_i (rdata1),
		.rdata2_i (rdata2),
		.raddr1_o (raddr1),
		.raddr2_o (raddr2),
		.ex_fwd_i (ex_fwd),
		.wb_i     (wb),
		.dec_o    (id_dec)
	);

	regfile regfile0 (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.wb_i      (wb),
		.raddr1_i  (raddr1),
		.raddr2_i  (raddr2),
		.dbg_addr_i(dbg_sel_i.reg_addr),
		.rdata1_o  (rdata1),
		.rdata2_o  (rdata2),
		.dbg_data_o(reg_dbg_data)
	);

	ex ex0 (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.dec_i   (id_dec),
		.ex_fwd_o(ex_fwd),
		.wb_o    (wb)
	);

endmodule

`default_nettype wire

// File: testbench/openmips_lite_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module openmips_lite_assertions (
	input wire                    clk,
	input wire                    arst_n_i,
	input wire                    inst_valid_i,
	input wire cpu_pkg::word_t    pc_i,
	input wire cpu_pkg::dbg_sel_t dbg_sel_i,
	input wire cpu_pkg::word_t    reg_dbg_data_i,
	input wire cpu_pkg::wb_t      wb_i
);

	// PC moves one word per accepted instruction
	pc_step_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		inst_valid_i |=> pc_i == $past(pc_i) + 32'd4)
		else $error("PC did not advance by 4 after an accepted instruction");

	pc_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		!inst_valid_i |=> pc_i == $past(pc_i))
		else $error("PC changed on an edge without an accepted instruction");

	// r0 stays zero whatever targets it
	r0_zero_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		dbg_sel_i.reg_addr == '0 |-> reg_dbg_data_i == '0)
		else $error("register r0 holds a nonzero value");

	wreg_known_a: assert property (@(posedge clk) disable iff (!arst_n_i)
		!$isunknown(wb_i.wreg))
		else $error("write-back enable is unknown");

endmodule

`default_nettype wire

// File: testbench/tb_openmips_lite.sv
`timescale 1ns/1ns
`default_nettype none

module tb_openmips_lite;

	localparam int             CLK_PERIOD    = 100;
	localparam int             NUM_CYCLES    = 2000;
	localparam int             SWEEP_CYCLES  = 34;
	localparam int             DRAIN_TIMEOUT = 8;
	localparam int             SEED          = 90431;
	localparam cpu_pkg::word_t RESET_PC      = 32'h0000_0000;

	logic              clk;
	logic              arst_n_i;
	logic              inst_valid_i;
	cpu_pkg::word_t    inst_i;
	cpu_pkg::dbg_sel_t dbg_sel_i;
	cpu_pkg::word_t    data_o;

	// seq_regs is program order, vis_regs is what the REG view should show
	cpu_pkg::word_t     seq_regs [cpu_pkg::NUM_REGS];
	cpu_pkg::word_t     vis_regs [cpu_pkg::NUM_REGS];
	logic               pipe_wr [3];
	cpu_pkg::reg_addr_t pipe_wd [3];
	cpu_pkg::word_t     pipe_data [3];
	cpu_pkg::word_t     model_pc;
	cpu_pkg::word_t     model_inst;
	int                 drain_cnt;

	openmips_lite #(
		.RESET_PC(RESET_PC)
	) i_dut (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.inst_valid_i(inst_valid_i),
		.inst_i      (inst_i),
		.dbg_sel_i   (dbg_sel_i),
		.data_o      (data_o)
	);

	bind openmips_lite openmips_lite_assertions i_assertions (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.inst_valid_i  (inst_valid_i),
		.pc_i          (pc),
		.dbg_sel_i     (dbg_sel_i),
		.reg_dbg_data_i(reg_dbg_data),
		.wb_i          (wb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic reset_model();
		for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
			seq_regs[i] = '0;
			vis_regs[i] = '0;
		end
		for (int i = 0; i < 3; i++) begin
			pipe_wr[i]   = 1'b0;
			pipe_wd[i]   = '0;
			pipe_data[i] = '0;
		end
		model_pc   = RESET_PC;
		model_inst = '0;
	endtask

	// Sequential semantics of the kept instruction set
	function automatic void reference_result(
		input  cpu_pkg::word_t     inst,
		output logic               wr,
		output cpu_pkg::reg_addr_t wd,
		output cpu_pkg::word_t     val
	);
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		logic [15:0]    imm;
		a   = seq_regs[inst[25:21]];
		b   = seq_regs[inst[20:16]];
		imm = inst[15:0];
		wr  = 1'b1;
		wd  = inst[20:16];
		val = '0;
		case (inst[31:26])
			cpu_pkg::OP_SPECIAL: begin
				wd = inst[15:11];
				case (inst[5:0])
					cpu_pkg::FN_ADDU: val = a + b;
					cpu_pkg::FN_SUBU: val = a - b;
					cpu_pkg::FN_AND:  val = a & b;
					cpu_pkg::FN_OR:   val = a | b;
					cpu_pkg::FN_XOR:  val = a ^ b;
					default:          wr  = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDIU: val = a + {{16{imm[15]}}, imm};
			cpu_pkg::OP_ANDI:  val = a & {16'h0000, imm};
			cpu_pkg::OP_ORI:   val = a | {16'h0000, imm};
			cpu_pkg::OP_XORI:  val = a ^ {16'h0000, imm};
			cpu_pkg::OP_LUI:   val = {imm, 16'h0000};
			default:           wr  = 1'b0;
		endcase
	endfunction

	// Called right after a rising edge, sees the inputs the DUT just sampled
	task automatic step_model();
		logic               wr;
		cpu_pkg::reg_addr_t wd;
		cpu_pkg::word_t     val;
		if (pipe_wr[2] && pipe_wd[2] != '0) begin
			vis_regs[pipe_wd[2]] = pipe_data[2];
		end
		for (int i = 2; i > 0; i--) begin
			pipe_wr[i]   = pipe_wr[i-1];
			pipe_wd[i]   = pipe_wd[i-1];
			pipe_data[i] = pipe_data[i-1];
		end
		pipe_wr[0] = 1'b0;
		if (inst_valid_i) begin
			model_pc   = model_pc + 32'd4;
			model_inst = inst_i;
			reference_result(inst_i, wr, wd, val);
			if (wr && wd != '0) begin
				seq_regs[wd] = val;
			end
			pipe_wr[0]   = wr;
			pipe_wd[0]   = wd;
			pipe_data[0] = val;
		end else begin
			model_inst = '0;
		end
	endtask

	function automatic logic writes_pending();
		return pipe_wr[0] || pipe_wr[1] || pipe_wr[2];
	endfunction

	// Register fields from r0..r7 so hazards are frequent
	function automatic cpu_pkg::word_t next_instruction();
		int              kind;
		logic [4:0]      rs;
		logic [4:0]      rt;
		logic [4:0]      rd;
		logic [15:0]     imm;
		cpu_pkg::funct_e fn;
		cpu_pkg::op_e    op;
		kind = $urandom_range(0, 15);
		rs   = 5'($urandom_range(0, 7));
		rt   = 5'($urandom_range(0, 7));
		rd   = 5'($urandom_range(0, 7));
		imm  = 16'($urandom);
		case ($urandom_range(0, 4))
			0:       fn = cpu_pkg::FN_ADDU;
			1:       fn = cpu_pkg::FN_SUBU;
			2:       fn = cpu_pkg::FN_AND;
			3:       fn = cpu_pkg::FN_OR;
			default: fn = cpu_pkg::FN_XOR;
		endcase
		case ($urandom_range(0, 4))
			0:       op = cpu_pkg::OP_ADDIU;
			1:       op = cpu_pkg::OP_ANDI;
			2:       op = cpu_pkg::OP_ORI;
			3:       op = cpu_pkg::OP_XORI;
			default: op = cpu_pkg::OP_LUI;
		endcase
		if (kind < 7) begin
			return {cpu_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
		end else if (kind < 14) begin
			return {op, rs, rt, imm};
		end else if (kind < 15) begin
			// Function codes below 0x20 are outside the kept set
			return {cpu_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, 6'($urandom_range(0, 31))};
		end
		// Opcodes 0x10 and up are outside the kept set
		return {6'($urandom_range(16, 63)), 26'($urandom)};
	endfunction

	// Sweep mode holds the strobe low and walks PC, INST, then r0..r31
	task automatic drive_inputs(input bit sweep, input int step);
		cpu_pkg::dbg_sel_t sel;
		if (sweep) begin
			inst_valid_i <= 1'b0;
			inst_i       <= '0;
			sel.reg_addr = 5'(step >= 2 ? step - 2 : 0);
			if (step == 0) begin
				sel.src = cpu_pkg::DBG_PC;
			end else if (step == 1) begin
				sel.src = cpu_pkg::DBG_INST;
			end else begin
				sel.src = cpu_pkg::DBG_REG;
			end
		end else begin
			inst_valid_i <= ($urandom_range(0, 3) != 0);
			inst_i       <= next_instruction();
			case ($urandom_range(0, 5))
				0:       sel.src = cpu_pkg::DBG_PC;
				1:       sel.src = cpu_pkg::DBG_INST;
				default: sel.src = cpu_pkg::DBG_REG;
			endcase
			sel.reg_addr = ($urandom_range(0, 7) == 0) ? 5'($urandom) : 5'($urandom_range(0, 7));
		end
		dbg_sel_i <= sel;
	endtask

	task automatic check_view();
		cpu_pkg::word_t expected;
		string          view;
		case (dbg_sel_i.src)
			cpu_pkg::DBG_PC: begin
				expected = model_pc;
				view     = "PC";
			end
			cpu_pkg::DBG_INST: begin
				expected = model_inst;
				view     = "INST";
			end
			cpu_pkg::DBG_REG: begin
				expected = vis_regs[dbg_sel_i.reg_addr];
				view     = $sformatf("REG r%0d", dbg_sel_i.reg_addr);
			end
			default: begin
				expected = '0;
				view     = "none";
			end
		endcase
		assert (data_o === expected) else begin
			$display("mismatch at %0t: data_o (%s view) expected %08h, got %08h",
				$time, view, expected, data_o);
			stop_with_failure();
		end
	endtask

	initial begin
		void'($urandom(SEED));
		arst_n_i     <= 1'b0;
		inst_valid_i <= 1'b0;
		inst_i       <= '0;
		dbg_sel_i    <= '0;
		reset_model();
		repeat (3) @(posedge clk);
		arst_n_i <= 1'b1;

		for (int cycle = 0; cycle < SWEEP_CYCLES + NUM_CYCLES; cycle++) begin
			@(posedge clk);
			step_model();
			drive_inputs(cycle < SWEEP_CYCLES, cycle);
			@(negedge clk);
			check_view();
		end

		// Let the last accepted writes retire
		drain_cnt = 0;
		while (writes_pending() && drain_cnt < DRAIN_TIMEOUT) begin
			@(posedge clk);
			step_model();
			drive_inputs(1'b1, drain_cnt + 2);
			@(negedge clk);
			check_view();
			drain_cnt++;
		end

		if (writes_pending()) begin
			$display("timeout: pending register writes did not retire within %0d cycles",
				DRAIN_TIMEOUT);
			stop_with_failure();
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/cpu_pkg.sv
hw/if_id.sv
hw/id.sv
hw/regfile.sv
hw/ex.sv
hw/openmips_lite.sv
testbench/openmips_lite_assertions.sv
testbench/tb_openmips_lite.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the openmips_lite testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_openmips_lite
BUILD_DIR=build

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
